/* all.f */
hw/mem_system_pkg.sv
hw/cache_way.sv
hw/way_select.sv
hw/four_bank_mem.sv
hw/cache_ctrl.sv
hw/mem_system.sv
verification/mem_system_tb.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= all.f
TOP       ?= mem_system_tb
RTL_TOP   ?= mem_system
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
JOBS      ?= 0

SOURCES := $(shell cat $(FILELIST))

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)

/* verification/mem_system_tb.sv */
/* testbench for the two-way data cache; a shadow memory and tag model predict each read
   and hit, and a compare process checks the DUT at every Done */
`default_nettype none

module mem_system_tb;
  import mem_system_pkg::*;

  logic              clk, reset, Rd, Wr;
  logic [ADDR_W-1:0] Addr;
  logic [DATA_W-1:0] DataIn, DataOut;
  logic              Done, Stall, CacheHit, err;

  logic [DATA_W-1:0] shadow_mem [32768]; // word view of the whole system
  logic [TAG_W-1:0]  tag_s   [2][256];
  logic              valid_s [2][256];
  logic              victim_s;           // one victim bit for the whole cache
  logic [DATA_W-1:0] exp_data;
  logic              exp_read, exp_hit, exp_err, timed_out;
  int                seed, errors, checks, test_errors, latency;

  mem_system #(.NUM_SETS(256)) UUT (
    .clk(clk), .reset(reset), .Addr(Addr), .DataIn(DataIn), .Rd(Rd), .Wr(Wr),
    .DataOut(DataOut), .Done(Done), .Stall(Stall), .CacheHit(CacheHit), .err(err));

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  function automatic logic [DATA_W-1:0] expected_read(input logic [ADDR_W-1:0] a);
    return shadow_mem[a[15:1]];
  endfunction

  function automatic logic predict_hit(input logic [ADDR_W-1:0] a);
    return (valid_s[0][a[10:3]] && (tag_s[0][a[10:3]] == a[15:11])) ||
           (valid_s[1][a[10:3]] && (tag_s[1][a[10:3]] == a[15:11]));
  endfunction

  function automatic logic [ADDR_W-1:0] addr_of(input logic [4:0] t, input logic [7:0] idx,
                                                input logic [1:0] w);
    return {t, idx, w, 1'b0};
  endfunction

  // miss fills the first invalid way, else the victim way
  task automatic update_model(input logic [ADDR_W-1:0] a, input logic is_wr,
                              input logic [DATA_W-1:0] d);
    logic [7:0] idx;
    logic       w;
    idx = a[10:3];
    if (!predict_hit(a)) begin
      w = !valid_s[0][idx] ? 1'b0 : (!valid_s[1][idx] ? 1'b1 : victim_s);
      tag_s[w][idx]   = a[15:11];
      valid_s[w][idx] = 1'b1;
    end
    victim_s = !victim_s; // flips on every compare
    if (is_wr) shadow_mem[a[15:1]] = d;
  endtask

  task automatic request(input logic [ADDR_W-1:0] a, input logic rd, input logic wr,
                         input logic [DATA_W-1:0] d);
    int   cycles;
    logic bad;
    if (timed_out) return;
    bad = a[0] || (rd && wr);
    @(negedge clk);
    check_value("Stall", 32'(Stall), 0); // idle before the strobe
    exp_read = rd && !bad;
    exp_err  = bad;
    exp_hit  = !bad && predict_hit(a);
    exp_data = expected_read(a);
    Addr     = a;
    DataIn   = d;
    Rd       = rd;
    Wr       = wr;
    cycles   = 0;
    do begin
      @(negedge clk);
      Rd = 1'b0; // one-cycle strobe
      Wr = 1'b0;
      cycles++;
      check_value("Stall", 32'(Stall), 1);
    end while (!Done && (cycles < 200));
    latency = cycles;
    if (!Done) begin
      timed_out = 1'b1;
      $display("timeout: no Done within 200 cycles for address 0x%h", a);
    end else if (!bad) begin
      update_model(a, wr, d);
    end
    @(posedge clk);
  endtask

  task automatic read_word(input logic [ADDR_W-1:0] a);
    request(a, 1'b1, 1'b0, '0);
  endtask

  task automatic write_word(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
    request(a, 1'b0, 1'b1, d);
  endtask

  task automatic end_test(input int num, input string what);
    $display("test %0d %s: %0d errors", num, what, errors - test_errors);
    test_errors = errors;
  endtask

  always @(negedge clk) begin
    if (!reset && Done) begin
      check_value("CacheHit", 32'(CacheHit), 32'(exp_hit));
      check_value("err", 32'(err), 32'(exp_err));
      if (exp_read) check_value("DataOut", 32'(DataOut), 32'(exp_data));
    end
  end

  initial begin
    int r;
    seed = 30;
    {errors, checks, test_errors, latency} = '0;
    {timed_out, exp_read, exp_hit, exp_err, victim_s} = '0;
    exp_data = '0;
    reset = 1'b1;
    Rd = 1'b0;
    Wr = 1'b0;
    Addr = '0;
    DataIn = '0;
    for (int i = 0; i < 32768; i++) shadow_mem[i] = '0;
    for (int i = 0; i < 256; i++) begin
      valid_s[0][i] = 1'b0;
      valid_s[1][i] = 1'b0;
      tag_s[0][i]   = '0;
      tag_s[1][i]   = '0;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    check_value("Stall", 32'(Stall), 0);
    check_value("Done", 32'(Done), 0);
    check_value("err", 32'(err), 0);
    read_word(16'h0010); // cold miss returns zero
    end_test(1, "reset and cold read");

    write_word(16'h0022, 16'hbeef);
    read_word(16'h0022);
    check_value("latency", latency, 1);
    end_test(2, "write then read hit");

    write_word(addr_of(5'd1, 8'd5, 2'd1), 16'h1111);
    write_word(addr_of(5'd2, 8'd5, 2'd2), 16'h2222);
    read_word(addr_of(5'd1, 8'd5, 2'd1));
    check_value("latency", latency, 1);
    read_word(addr_of(5'd2, 8'd5, 2'd2));
    check_value("latency", latency, 1);
    end_test(3, "two tags in one set");

    read_word(addr_of(5'd3, 8'd5, 2'd0)); // full set evicts a dirty way
    read_word(addr_of(5'd1, 8'd5, 2'd1));
    read_word(addr_of(5'd2, 8'd5, 2'd2));
    end_test(4, "eviction and writeback");

    read_word(16'h0023);
    write_word(16'h0025, 16'h5555);
    request(16'h0022, 1'b1, 1'b1, 16'h1234);
    read_word(16'h0022);
    check_value("latency", latency, 1);
    read_word(16'h0024); // word beside the odd write stays untouched
    end_test(5, "error requests");

    for (int n = 0; n < 300; n++) begin
      r = $random(seed);
      // tags 0..3, sets 0x10..0x13
      if (r[6]) write_word(addr_of(5'(r[1:0]), 8'h10 + 8'(r[3:2]), r[5:4]), r[31:16]);
      else      read_word(addr_of(5'(r[1:0]), 8'h10 + 8'(r[3:2]), r[5:4]));
    end
    end_test(6, "random reads and writes");

    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, 32'(timed_out));
    if ((errors == 0) && !timed_out) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hw/mem_system.sv */
/* top of the two-way write-back data cache: ways, selector, controller and banked
   memory, with the way and memory address muxing */
`default_nettype none

module mem_system #(
  parameter int NUM_SETS = 256
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [mem_system_pkg::ADDR_W-1:0] Addr,
  input  logic [mem_system_pkg::DATA_W-1:0] DataIn,
  input  logic                            Rd,
  input  logic                            Wr,
  output logic [mem_system_pkg::DATA_W-1:0] DataOut,
  output logic                            Done,
  output logic                            Stall,
  output logic                            CacheHit,
  output logic                            err
);
  import mem_system_pkg::*;

  ctrl_state_t       state;
  logic              comp, write, valid_in, mem_rd, mem_wr, mem_stall;
  logic              sel_hit, sel_dirty, way_en0, way_en1;
  logic              hit0, valid0, dirty0, hit1, valid1, dirty1;
  logic [WORD_W-1:0] word_sel;
  logic [TAG_W-1:0]  tag, victim_tag, tag_out0, tag_out1;
  logic [INDEX_W-1:0]  index;
  logic [OFFSET_W-1:0] way_offset;
  logic [DATA_W-1:0] way_data_in, way_data, data_out0, data_out1, mem_data_out;
  logic [ADDR_W-1:0] mem_addr;

  assign tag   = Addr[ADDR_W-1 -: TAG_W];
  assign index = Addr[OFFSET_W +: INDEX_W];

  // requester word in compare, fill data from memory on install
  assign way_offset  = comp ? Addr[OFFSET_W-1:0] : {word_sel, 1'b0};
  assign way_data_in = comp ? DataIn : mem_data_out;

  // writeback goes to the victim's block, allocate reads run MEM_LATENCY ahead of installs
  assign mem_addr = mem_wr ? {victim_tag, index, word_sel, 1'b0}
                           : {tag, index, word_sel + WORD_W'(MEM_LATENCY), 1'b0};

  cache_way #(.NUM_SETS(NUM_SETS)) u_way0 (
    .clk(clk), .reset(reset), .enable(way_en0), .comp(comp), .write(write),
    .valid_in(valid_in), .tag_in(tag), .index(index), .offset(way_offset),
    .data_in(way_data_in), .hit(hit0), .dirty(dirty0), .valid(valid0),
    .tag_out(tag_out0), .data_out(data_out0));

  cache_way #(.NUM_SETS(NUM_SETS)) u_way1 (
    .clk(clk), .reset(reset), .enable(way_en1), .comp(comp), .write(write),
    .valid_in(valid_in), .tag_in(tag), .index(index), .offset(way_offset),
    .data_in(way_data_in), .hit(hit1), .dirty(dirty1), .valid(valid1),
    .tag_out(tag_out1), .data_out(data_out1));

  way_select u_sel (
    .clk(clk), .reset(reset), .state(state),
    .hit0(hit0), .valid0(valid0), .dirty0(dirty0), .tag_out0(tag_out0), .data_out0(data_out0),
    .hit1(hit1), .valid1(valid1), .dirty1(dirty1), .tag_out1(tag_out1), .data_out1(data_out1),
    .way_en0(way_en0), .way_en1(way_en1), .hit(sel_hit), .dirty(sel_dirty),
    .victim_tag(victim_tag), .data_out(way_data));

  cache_ctrl u_ctrl (
    .clk(clk), .reset(reset), .rd(Rd), .wr(Wr), .misaligned(Addr[0]),
    .hit(sel_hit), .dirty(sel_dirty), .mem_stall(mem_stall), .state(state),
    .comp(comp), .write(write), .valid_in(valid_in), .word_sel(word_sel),
    .mem_rd(mem_rd), .mem_wr(mem_wr), .stall(Stall), .done(Done),
    .cache_hit(CacheHit), .err(err));

  four_bank_mem u_mem (
    .clk(clk), .reset(reset), .addr(mem_addr), .data_in(way_data), .wr(mem_wr),
    .rd(mem_rd), .data_out(mem_data_out), .stall(mem_stall));

  assign DataOut = way_data;

endmodule

`default_nettype wire

/* hw/cache_ctrl.sv */
/* cache controller FSM: compare, writeback of a dirty victim, block allocate and retry;
   drives the way controls, the memory strobes and the requester's Stall and Done */
`default_nettype none

module cache_ctrl (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            rd,
  input  logic                            wr,
  input  logic                            misaligned,
  input  logic                            hit,
  input  logic                            dirty,
  input  logic                            mem_stall,
  output mem_system_pkg::ctrl_state_t     state,
  output logic                            comp,
  output logic                            write,
  output logic                            valid_in,
  output logic [mem_system_pkg::WORD_W-1:0] word_sel,
  output logic                            mem_rd,
  output logic                            mem_wr,
  output logic                            stall,
  output logic                            done,
  output logic                            cache_hit,
  output logic                            err
);
  import mem_system_pkg::*;

  localparam logic [3:0] LAT   = 4'(MEM_LATENCY);
  localparam logic [3:0] WORDS = 4'(WORDS_PER_BLOCK);
  // allocate counts the installed word, which lags the read by MEM_LATENCY
  localparam logic [WORD_W-1:0] ALLOC_START = WORD_W'(WORDS_PER_BLOCK - MEM_LATENCY);

  ctrl_state_t next_state;
  logic        is_wr;       // request kind, held until Done
  logic        in_wb;
  logic        in_alloc;
  logic        installing;
  logic [3:0]  alloc_step;

  assign in_wb      = (state >= WB0) && (state <= WB3);
  assign in_alloc   = (state >= ALLOC0) && (state <= ALLOC5);
  assign alloc_step = state - ALLOC0;
  assign installing = in_alloc && (alloc_step >= LAT);

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (rd || wr) next_state = (misaligned || (rd && wr)) ? ERROR : COMPARE;
      end
      COMPARE: next_state = hit ? IDLE : (dirty ? WB0 : ALLOC0);
      RETRY:   next_state = IDLE;
      ERROR:   next_state = IDLE;
      default: begin
        // WB and ALLOC walk up the encoding, frozen by bank stall
        if (!mem_stall) next_state = ctrl_state_t'(state + 4'd1);
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) state <= IDLE;
    else       state <= next_state;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      is_wr <= 1'b0;
    end else if ((state == IDLE) && (rd || wr)) begin
      is_wr <= wr;
    end
  end

  // word counter for writeback and allocate
  always_ff @(posedge clk) begin
    if (reset) begin
      word_sel <= '0;
    end else if (state == COMPARE) begin
      word_sel <= dirty ? '0 : ALLOC_START;
    end else if ((state == WB3) && !mem_stall) begin
      word_sel <= ALLOC_START;
    end else if ((in_wb || in_alloc) && !mem_stall) begin
      word_sel <= word_sel + 1'b1;
    end
  end

  assign comp     = (state == COMPARE) || (state == RETRY);
  assign write    = (comp && is_wr) || installing;
  assign valid_in = (state == ALLOC5);          // last word commits the line
  assign mem_wr   = in_wb;
  assign mem_rd   = in_alloc && (alloc_step < WORDS);

  assign stall     = (state != IDLE);
  assign cache_hit = (state == COMPARE) && hit;
  assign done      = cache_hit || (state == RETRY) || (state == ERROR);
  assign err       = (state == ERROR);

  // a request always ends in IDLE right after done
  a_done_ends_request: assert property (@(posedge clk) disable iff (reset)
    done |=> (state == IDLE));

endmodule

`default_nettype wire

/* hw/four_bank_mem.sv */
/* backing word memory in four banks interleaved on word bits 2..1; reads return data
   MEM_LATENCY cycles after the strobe, a bank stays busy for MEM_LATENCY cycles */
`default_nettype none

module four_bank_mem (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [mem_system_pkg::ADDR_W-1:0] addr,
  input  logic [mem_system_pkg::DATA_W-1:0] data_in,
  input  logic                            wr,
  input  logic                            rd,
  output logic [mem_system_pkg::DATA_W-1:0] data_out,
  output logic                            stall
);
  import mem_system_pkg::*;

  localparam int NUM_BANKS = WORDS_PER_BLOCK;
  localparam int ROW_W     = ADDR_W - OFFSET_W;
  localparam int BANK_ROWS = 2 ** ROW_W;
  localparam int CNT_W     = $clog2(MEM_LATENCY + 1);
  localparam int LAST      = MEM_LATENCY - 1;

  logic [DATA_W-1:0] mem_arr  [NUM_BANKS][BANK_ROWS];
  logic [CNT_W-1:0]  busy_cnt [NUM_BANKS];
  logic [ADDR_W-2:0] rd_pipe  [MEM_LATENCY];  // word address of reads in flight
  logic [WORD_W-1:0] bank;
  logic [ROW_W-1:0]  row;
  logic              accept;

  assign bank   = addr[OFFSET_W-1:1];
  assign row    = addr[ADDR_W-1:OFFSET_W];
  assign stall  = (rd || wr) && (busy_cnt[bank] != '0);
  assign accept = (rd || wr) && !stall;

  initial begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      for (int r = 0; r < BANK_ROWS; r++) begin
        mem_arr[b][r] = '0;
      end
    end
  end

  always @(posedge clk) begin
    if (accept && wr) mem_arr[bank][row] <= data_in;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int b = 0; b < NUM_BANKS; b++) busy_cnt[b] <= '0;
    end else begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        if (accept && (bank == WORD_W'(b))) busy_cnt[b] <= CNT_W'(MEM_LATENCY);
        else if (busy_cnt[b] != '0) busy_cnt[b] <= busy_cnt[b] - 1'b1;
      end
    end
  end

  // address shift line, one stage per cycle of latency
  always_ff @(posedge clk) begin
    rd_pipe[0] <= addr[ADDR_W-1:1];
    for (int i = 1; i < MEM_LATENCY; i++) rd_pipe[i] <= rd_pipe[i-1];
  end

  assign data_out = mem_arr[rd_pipe[LAST][WORD_W-1:0]][rd_pipe[LAST][ADDR_W-2:WORD_W]];

endmodule

`default_nettype wire

/* hw/way_select.sv */
/* merges the two ways' lookup results, picks the victim way and steers its data and tag;
   hit, dirty and victim are captured in COMPARE and held through a miss */
`default_nettype none

module way_select (
  input  logic                            clk,
  input  logic                            reset,
  input  mem_system_pkg::ctrl_state_t     state,
  input  logic                            hit0,
  input  logic                            valid0,
  input  logic                            dirty0,
  input  logic [mem_system_pkg::TAG_W-1:0]  tag_out0,
  input  logic [mem_system_pkg::DATA_W-1:0] data_out0,
  input  logic                            hit1,
  input  logic                            valid1,
  input  logic                            dirty1,
  input  logic [mem_system_pkg::TAG_W-1:0]  tag_out1,
  input  logic [mem_system_pkg::DATA_W-1:0] data_out1,
  output logic                            way_en0,
  output logic                            way_en1,
  output logic                            hit,
  output logic                            dirty,
  output logic [mem_system_pkg::TAG_W-1:0]  victim_tag,
  output logic [mem_system_pkg::DATA_W-1:0] data_out
);
  import mem_system_pkg::*;

  logic vhit0, vhit1, live_hit, live_dirty, live_sel;
  logic victim_bit, sel_q, hit_q, dirty_q, sel;
  logic in_compare, live_view;

  assign in_compare = (state == COMPARE);
  assign live_view  = in_compare || (state == RETRY); // both ways looked up

  assign vhit0    = hit0 && valid0;
  assign vhit1    = hit1 && valid1;
  assign live_hit = vhit0 || vhit1;
  // hit way wins, else first invalid way, else alternating bit
  assign live_sel   = live_hit ? vhit1 : (!valid0 ? 1'b0 : (!valid1 ? 1'b1 : victim_bit));
  assign live_dirty = live_sel ? (valid1 && dirty1) : (valid0 && dirty0);

  assign sel      = live_view ? live_sel : sel_q;
  assign data_out = sel ? data_out1 : data_out0;
  assign way_en0  = live_view || !sel_q;
  assign way_en1  = live_view || sel_q;
  assign hit      = in_compare ? live_hit : hit_q;
  assign dirty    = in_compare ? live_dirty : dirty_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      victim_bit <= 1'b0;
      sel_q      <= 1'b0;
      hit_q      <= 1'b0;
      dirty_q    <= 1'b0;
    end else if (in_compare) begin
      victim_bit <= !victim_bit; // flips on every lookup, hit or miss
      sel_q      <= live_sel;
      hit_q      <= live_hit;
      dirty_q    <= live_dirty;
    end
  end

  always_ff @(posedge clk) begin
    if (in_compare) victim_tag <= live_sel ? tag_out1 : tag_out0;
  end

  // a block lives in at most one way of its set
  a_single_way_hit: assert property (@(posedge clk) disable iff (reset)
    !(vhit0 && vhit1));

endmodule

`default_nettype wire

/* hw/cache_way.sv */
/* one way of the cache: tag, valid, dirty and data arrays per set; compare-write on a hit
   and word install from memory when comp is low */
`default_nettype none

module cache_way #(
  parameter int NUM_SETS = 256
) (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              enable,
  input  logic                              comp,
  input  logic                              write,
  input  logic                              valid_in,
  input  logic [mem_system_pkg::TAG_W-1:0]    tag_in,
  input  logic [mem_system_pkg::INDEX_W-1:0]  index,
  input  logic [mem_system_pkg::OFFSET_W-1:0] offset,
  input  logic [mem_system_pkg::DATA_W-1:0]   data_in,
  output logic                              hit,
  output logic                              dirty,
  output logic                              valid,
  output logic [mem_system_pkg::TAG_W-1:0]    tag_out,
  output logic [mem_system_pkg::DATA_W-1:0]   data_out
);
  import mem_system_pkg::*;

  logic [TAG_W-1:0]  tag_arr  [NUM_SETS];
  logic [DATA_W-1:0] data_arr [NUM_SETS][WORDS_PER_BLOCK];
  logic [NUM_SETS-1:0] valid_arr;
  logic [NUM_SETS-1:0] dirty_arr;
  logic [WORD_W-1:0] word;
  logic              hit_write;     // compare write that lands on this way
  logic              install;       // fill word coming back from memory

  assign word      = offset[OFFSET_W-1:1];
  assign hit_write = enable && write && comp && hit && valid;
  assign install   = enable && write && !comp;

  // lookup is combinational on the current index
  assign tag_out  = tag_arr[index];
  assign valid    = valid_arr[index];
  assign dirty    = dirty_arr[index];
  assign data_out = data_arr[index][word];
  assign hit      = enable && (tag_arr[index] == tag_in);

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_arr <= '0;
      dirty_arr <= '0;
    end else if (hit_write) begin
      dirty_arr[index] <= 1'b1;
    end else if (install) begin
      valid_arr[index] <= valid_in; // set only with the last word
      dirty_arr[index] <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (hit_write) begin
      data_arr[index][word] <= data_in;
    end else if (install) begin
      data_arr[index][word] <= data_in;
      tag_arr[index]        <= tag_in;
    end
  end

  // controller only compares while the selector has this way switched on
  a_comp_needs_enable: assert property (@(posedge clk) disable iff (reset)
    comp |-> enable);

endmodule

`default_nettype wire

/* hw/mem_system_pkg.sv */
/* shared geometry, widths and controller state encoding for the two-way data cache
   and its banked backing memory; imported by every RTL module */
`default_nettype none

package mem_system_pkg;

  localparam int ADDR_W          = 16; // byte address
  localparam int DATA_W          = 16; // one word
  localparam int TAG_W           = 5;  // addr 15..11
  localparam int INDEX_W         = 8;  // addr 10..3
  localparam int OFFSET_W        = 3;  // addr 2..0, bit 0 always zero
  localparam int WORDS_PER_BLOCK = 4;
  localparam int WORD_W          = $clog2(WORDS_PER_BLOCK); // word select, addr 2..1
  localparam int MEM_LATENCY     = 2;  // read strobe to valid data, in cycles

  // keep the order since WB3 + 1 is ALLOC0 and ALLOC5 + 1 is RETRY
  typedef enum logic [3:0] {
    IDLE,
    COMPARE,
    WB0, WB1, WB2, WB3,        // write victim block back, one word each
    ALLOC0, ALLOC1, ALLOC2,    // read new block
    ALLOC3, ALLOC4, ALLOC5,    // installs trail the reads by MEM_LATENCY
    RETRY,                     // second compare, always hits
    ERROR
  } ctrl_state_t;

endpackage

`default_nettype wire
